/* logic/cacheCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheCtrl (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  // request FIFO side
  input  wire logic                          reqValid_i,
  input  cachePkg::reqT                      reqData_i,
  output logic                               reqPop_o,
  // refill FIFO side
  input  wire logic                          beatValid_i,
  input  cachePkg::beatT                     beatData_i,
  output logic                               beatPop_o,
  // memory and core
  output logic                               memReqValid_o,
  output cachePkg::addrT                     memReqAddr_o,
  output logic                               rdValid_o,
  // tag store
  output logic                               lookupEn_o,
  output cachePkg::indexT                    lookupIndex_o,
  output cachePkg::tagT                      lookupTag_o,
  input  wire logic                          hit_i,
  input  wire logic                          hitWay_i,
  input  wire logic                          victimWay_i,
  output logic                               fillEn_o,
  output cachePkg::indexT                    fillIndex_o,
  output cachePkg::tagT                      fillTag_o,
  output logic                               fillWay_o,
  // data store
  output logic                               readEn_o,
  output cachePkg::indexT                    readIndex_o,
  output logic [cachePkg::beatBits-1:0]      readWordSel_o,
  output logic                               readWay_o,
  output logic                               beatWe_o,
  output cachePkg::indexT                    beatIndex_o,
  output logic [cachePkg::beatBits-1:0]      beatNum_o,
  output logic                               beatWay_o,
  output cachePkg::wordT                     beatWord_o
);

  typedef enum logic [1:0] {idle, compare, miss, refill} stateT;

  stateT                           state;
  stateT                           nextState;
  cachePkg::addrT                  reqAddrQ;
  cachePkg::addrT                  lookupAddr;
  cachePkg::indexT                 curIndex;
  cachePkg::tagT                   curTag;
  logic                            replayQ;
  logic                            victimQ;
  logic [cachePkg::beatBits-1:0]   beatCnt;
  logic                            acceptNew;
  logic                            replayLookup;
  logic                            lastBeat;

  assign curIndex = cachePkg::addrIndex(reqAddrQ);
  assign curTag   = cachePkg::addrTag(reqAddrQ);

  // new request while idle or behind a hit in compare
  assign acceptNew    = ((state == idle) && !replayQ) || ((state == compare) && hit_i);
  assign reqPop_o     = reqValid_i && acceptNew;
  assign replayLookup = (state == idle) && replayQ;

  assign beatPop_o = beatValid_i && (state == refill);
  assign lastBeat  = beatPop_o && (beatCnt == cachePkg::beatBits'(cachePkg::beatsPerLine - 1));

  always_comb begin
    nextState = state;
    unique case (state)
      idle: begin
        if (replayQ || reqValid_i) begin
          nextState = compare;
        end
      end
      compare: begin
        if (!hit_i) begin
          nextState = miss;
        end else if (!reqValid_i) begin
          nextState = idle;
        end
      end
      miss: begin
        nextState = refill;
      end
      refill: begin
        if (lastBeat) begin
          nextState = idle;
        end
      end
      default: nextState = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= idle;
      replayQ     <= 1'b0;
      beatCnt     <= '0;
      rdValid_o   <= 1'b0;
    end else begin
      state     <= nextState;
      rdValid_o <= (state == compare) && hit_i;
      if (lastBeat) begin
        replayQ <= 1'b1;
      end else if (replayLookup) begin
        replayQ <= 1'b0;
      end
      if (beatPop_o) begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reqPop_o) begin
      reqAddrQ <= reqData_i.addr;
    end
    if ((state == compare) && !hit_i) begin
      victimQ <= victimWay_i;
    end
  end

  // lookup of the popped request or a replay after refill
  assign lookupAddr    = replayQ ? reqAddrQ : reqData_i.addr;
  assign lookupEn_o    = reqPop_o || replayLookup;
  assign lookupIndex_o = cachePkg::addrIndex(lookupAddr);
  assign lookupTag_o   = cachePkg::addrTag(lookupAddr);

  assign readEn_o      = (state == compare) && hit_i;
  assign readIndex_o   = curIndex;
  assign readWordSel_o = cachePkg::addrWordSel(reqAddrQ);
  assign readWay_o     = hitWay_i;

  assign memReqValid_o = (state == miss);
  assign memReqAddr_o  = {curTag, curIndex, {cachePkg::offsetBits{1'b0}}};

  // beats go to the victim way in order from the lowest word
  assign beatWe_o    = beatPop_o;
  assign beatIndex_o = curIndex;
  assign beatNum_o   = beatCnt;
  assign beatWay_o   = victimQ;
  assign beatWord_o  = beatData_i.data;

  assign fillEn_o    = lastBeat;
  assign fillIndex_o = curIndex;
  assign fillTag_o   = curTag;
  assign fillWay_o   = victimQ;

  // no beat of an earlier line may still wait when a new line is asked for
  oneMissOutstanding: assert property (
    @(posedge clk) disable iff (!rst_n)
    memReqValid_o |-> !beatValid_i
  ) else $error("cacheCtrl: memory request issued while refill beats are still queued");

endmodule

`default_nettype wire

/* logic/cachePkg.sv */
`default_nettype none

package cachePkg;

  // address split into tag, index and byte offset
  localparam int addrWidth    = 32;
  localparam int dataWidth    = 64;
  localparam int offsetBits   = 5;
  localparam int indexBits    = 6;
  localparam int tagBits      = addrWidth - indexBits - offsetBits;
  localparam int numSets      = 1 << indexBits;
  localparam int beatsPerLine = 4;
  localparam int beatBits     = 2;
  localparam int fifoDepth    = 4;

  // one word slot per way, set and beat
  localparam int storeWords   = 2 * numSets * beatsPerLine;

  typedef logic [addrWidth-1:0] addrT;
  typedef logic [dataWidth-1:0] wordT;
  typedef logic [tagBits-1:0]   tagT;
  typedef logic [indexBits-1:0] indexT;

  typedef struct packed {
    addrT addr;
  } reqT;

  typedef struct packed {
    wordT data;
  } beatT;

  function automatic tagT addrTag(input addrT a);
    return a[addrWidth-1 -: tagBits];
  endfunction

  function automatic indexT addrIndex(input addrT a);
    return a[offsetBits +: indexBits];
  endfunction

  // 64-bit word within the line
  function automatic logic [beatBits-1:0] addrWordSel(input addrT a);
    return a[offsetBits-1 -: beatBits];
  endfunction

endpackage

`default_nettype wire

/* logic/cacheTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheTop (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       reqValid_i,
  input  cachePkg::addrT  reqAddr_i,
  output logic            reqCredit_o,
  output logic            rdValid_o,
  output cachePkg::wordT  rdData_o,
  output logic            memReqValid_o,
  output cachePkg::addrT  memReqAddr_o,
  input  wire logic       memBeatValid_i,
  input  cachePkg::wordT  memBeatData_i,
  output logic            memCredit_o
);

  cachePkg::reqT                   reqIn;
  cachePkg::reqT                   reqHead;
  cachePkg::beatT                  beatIn;
  cachePkg::beatT                  beatHead;
  logic                            reqValid;
  logic                            reqPop;
  logic                            beatValid;
  logic                            beatPop;

  logic                            lookupEn;
  cachePkg::indexT                 lookupIndex;
  cachePkg::tagT                   lookupTag;
  logic                            hit;
  logic                            hitWay;
  logic                            victimWay;
  logic                            fillEn;
  cachePkg::indexT                 fillIndex;
  cachePkg::tagT                   fillTag;
  logic                            fillWay;

  logic                            readEn;
  cachePkg::indexT                 readIndex;
  logic [cachePkg::beatBits-1:0]   readWordSel;
  logic                            readWay;
  logic                            beatWe;
  cachePkg::indexT                 beatIndex;
  logic [cachePkg::beatBits-1:0]   beatNum;
  logic                            beatWay;
  cachePkg::wordT                  beatWord;

  assign reqIn.addr  = reqAddr_i;
  assign beatIn.data = memBeatData_i;

  // core request queue
  creditFifo #(.payloadT(cachePkg::reqT), .depth(cachePkg::fifoDepth)) reqFifo (
    .clk, .rst_n,
    .pushValid_i (reqValid_i),
    .pushData_i  (reqIn),
    .popReady_i  (reqPop),
    .popValid_o  (reqValid),
    .popData_o   (reqHead),
    .credit_o    (reqCredit_o)
  );

  // line refill beats from memory
  creditFifo #(.payloadT(cachePkg::beatT), .depth(cachePkg::fifoDepth)) refillFifo (
    .clk, .rst_n,
    .pushValid_i (memBeatValid_i),
    .pushData_i  (beatIn),
    .popReady_i  (beatPop),
    .popValid_o  (beatValid),
    .popData_o   (beatHead),
    .credit_o    (memCredit_o)
  );

  cacheCtrl ctrl (
    .clk, .rst_n,
    .reqValid_i    (reqValid),     .reqData_i     (reqHead),     .reqPop_o      (reqPop),
    .beatValid_i   (beatValid),    .beatData_i    (beatHead),    .beatPop_o     (beatPop),
    .memReqValid_o (memReqValid_o), .memReqAddr_o (memReqAddr_o), .rdValid_o    (rdValid_o),
    .lookupEn_o    (lookupEn),     .lookupIndex_o (lookupIndex), .lookupTag_o   (lookupTag),
    .hit_i         (hit),          .hitWay_i      (hitWay),      .victimWay_i   (victimWay),
    .fillEn_o      (fillEn),       .fillIndex_o   (fillIndex),   .fillTag_o     (fillTag),
    .fillWay_o     (fillWay),
    .readEn_o      (readEn),       .readIndex_o   (readIndex),   .readWordSel_o (readWordSel),
    .readWay_o     (readWay),
    .beatWe_o      (beatWe),       .beatIndex_o   (beatIndex),   .beatNum_o     (beatNum),
    .beatWay_o     (beatWay),      .beatWord_o    (beatWord)
  );

  tagStore tags (
    .clk, .rst_n,
    .lookupEn_i    (lookupEn),
    .lookupIndex_i (lookupIndex),
    .lookupTag_i   (lookupTag),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay),
    .fillEn_i      (fillEn),
    .fillIndex_i   (fillIndex),
    .fillTag_i     (fillTag),
    .fillWay_i     (fillWay)
  );

  dataStore data (
    .clk, .rst_n,
    .readEn_i      (readEn),
    .readIndex_i   (readIndex),
    .readWordSel_i (readWordSel),
    .readWay_i     (readWay),
    .rdData_o      (rdData_o),
    .beatWe_i      (beatWe),
    .beatIndex_i   (beatIndex),
    .beatNum_i     (beatNum),
    .beatWay_i     (beatWay),
    .beatData_i    (beatWord)
  );

endmodule

`default_nettype wire

/* logic/creditFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module creditFifo #(
  parameter type payloadT = logic,
  parameter int  depth    = cachePkg::fifoDepth
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic pushValid_i,
  input  payloadT   pushData_i,
  input  wire logic popReady_i,
  output logic      popValid_o,
  output payloadT   popData_o,
  output logic      credit_o
);

  localparam int ptrW   = (depth > 1) ? $clog2(depth) : 1;
  localparam int countW = $clog2(depth + 1);

  payloadT           mem [depth];
  logic [ptrW-1:0]   wrPtr;
  logic [ptrW-1:0]   rdPtr;
  logic [countW-1:0] count;
  logic              push;
  logic              pop;

  assign push = pushValid_i;
  assign pop  = popValid_o && popReady_i;

  assign popValid_o = (count != '0);
  assign popData_o  = mem[rdPtr];

  // freed slot goes straight back to the producer
  assign credit_o = pop;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= pushData_i;
    end
  end

  // producer must hold a credit for every push
  noOverflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    pushValid_i |-> (count < countW'(depth))
  ) else $error("creditFifo: push while full, producer sent without a credit");

  // consumer only pops what it sees
  noUnderflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    popReady_i |-> popValid_o
  ) else $error("creditFifo: pop requested while empty");

endmodule

`default_nettype wire

/* logic/dataStore.sv */
`timescale 1ns/1ps
`default_nettype none

module dataStore (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          readEn_i,
  input  cachePkg::indexT                    readIndex_i,
  input  wire logic [cachePkg::beatBits-1:0] readWordSel_i,
  input  wire logic                          readWay_i,
  output cachePkg::wordT                     rdData_o,
  input  wire logic                          beatWe_i,
  input  cachePkg::indexT                    beatIndex_i,
  input  wire logic [cachePkg::beatBits-1:0] beatNum_i,
  input  wire logic                          beatWay_i,
  input  cachePkg::wordT                     beatData_i
);

  localparam int addrW = 1 + cachePkg::indexBits + cachePkg::beatBits;

  // flat word array addressed by way, set and word
  cachePkg::wordT   mem [cachePkg::storeWords];
  logic [addrW-1:0] wrAddr;
  logic [addrW-1:0] rdAddr;

  assign wrAddr = {beatWay_i, beatIndex_i, beatNum_i};
  assign rdAddr = {readWay_i, readIndex_i, readWordSel_i};

  always_ff @(posedge clk) begin
    if (beatWe_i) begin
      mem[wrAddr] <= beatData_i;
    end
  end

  // word out one cycle after the read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdData_o <= '0;
    end else if (readEn_i) begin
      rdData_o <= mem[rdAddr];
    end
  end

endmodule

`default_nettype wire

/* logic/tagStore.sv */
`timescale 1ns/1ps
`default_nettype none

module tagStore (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            lookupEn_i,
  input  cachePkg::indexT      lookupIndex_i,
  input  cachePkg::tagT        lookupTag_i,
  output logic                 hit_o,
  output logic                 hitWay_o,
  output logic                 victimWay_o,
  input  wire logic            fillEn_i,
  input  cachePkg::indexT      fillIndex_i,
  input  cachePkg::tagT        fillTag_i,
  input  wire logic            fillWay_i
);

  cachePkg::tagT                  tag0 [cachePkg::numSets];
  cachePkg::tagT                  tag1 [cachePkg::numSets];
  logic [cachePkg::numSets-1:0]   valid0;
  logic [cachePkg::numSets-1:0]   valid1;
  // set bit means way 1 is the next victim
  logic [cachePkg::numSets-1:0]   lru;

  logic hit0Now;
  logic hit1Now;
  logic hit0Q;
  logic hit1Q;
  logic victimQ;

  assign hit0Now = valid0[lookupIndex_i] && (tag0[lookupIndex_i] == lookupTag_i);
  assign hit1Now = valid1[lookupIndex_i] && (tag1[lookupIndex_i] == lookupTag_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid0 <= '0;
      valid1 <= '0;
      lru    <= '0;
    end else if (fillEn_i) begin
      if (fillWay_i) begin
        valid1[fillIndex_i] <= 1'b1;
      end else begin
        valid0[fillIndex_i] <= 1'b1;
      end
      lru[fillIndex_i] <= !fillWay_i;
    end else if (lookupEn_i && (hit0Now || hit1Now)) begin
      // way just used becomes most recent
      lru[lookupIndex_i] <= hit0Now;
    end
  end

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      if (fillWay_i) begin
        tag1[fillIndex_i] <= fillTag_i;
      end else begin
        tag0[fillIndex_i] <= fillTag_i;
      end
    end
  end

  // registered lookup result
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hit0Q   <= 1'b0;
      hit1Q   <= 1'b0;
      victimQ <= 1'b0;
    end else if (lookupEn_i) begin
      hit0Q   <= hit0Now;
      hit1Q   <= hit1Now;
      victimQ <= lru[lookupIndex_i];
    end else begin
      hit0Q <= 1'b0;
      hit1Q <= 1'b0;
    end
  end

  assign hit_o       = hit0Q || hit1Q;
  assign hitWay_o    = hit1Q;
  assign victimWay_o = victimQ;

  // a line may live in one way only
  singleWayHit: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(hit0Q && hit1Q)
  ) else $error("tagStore: same tag valid in both ways");

endmodule

`default_nettype wire

/* runSim.sh */
#!/usr/bin/env bash
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module cacheTb -f sources.f -o cacheSim \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/cacheSim 2>&1 | tee sim.log

grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log && exit 0
echo "simulation ended without a verdict"
exit 1

/* sources.f */
+incdir+tests
logic/cachePkg.sv
logic/creditFifo.sv
logic/tagStore.sv
logic/dataStore.sv
logic/cacheCtrl.sv
logic/cacheTop.sv
tests/cacheTb.sv

/* tests/cacheTbChecks.svh */
`ifndef CACHE_TB_CHECKS_SVH
`define CACHE_TB_CHECKS_SVH

// read data against the expected word
task automatic checkWord(input string what, input cachePkg::wordT got,
                         input cachePkg::wordT exp, output bit ok);
  ok = (got === exp);
  if (!ok) begin
    errCount++;
    $display("Fail %0t ns: %s read data %h, expected %h", $time, what, got, exp);
  end
endtask

// line address on the memory request port
task automatic checkAddr(input string what, input cachePkg::addrT got,
                         input cachePkg::addrT exp, output bit ok);
  ok = (got === exp);
  if (!ok) begin
    errCount++;
    $display("Fail %0t ns: %s memory request address %h, expected %h", $time, what, got, exp);
  end
endtask

// hit or miss as seen on the memory request port
task automatic checkHit(input string what, input logic gotMiss, input logic expMiss,
                        output bit ok);
  ok = (gotMiss === expMiss);
  if (!ok) begin
    errCount++;
    $display("Fail %0t ns: %s was a %s, expected a %s", $time, what,
             gotMiss ? "miss" : "hit", expMiss ? "miss" : "hit");
  end
endtask

`endif

/* tests/cacheTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheTb;

  localparam int maxReq    = 64;
  localparam int halfCycle = 10;

  logic           clk;
  logic           rst_n;
  logic           reqValid;
  cachePkg::addrT reqAddr;
  logic           reqCredit;
  logic           rdValid;
  cachePkg::wordT rdData;
  logic           memReqValid;
  cachePkg::addrT memReqAddr;
  logic           memBeatValid;
  cachePkg::wordT memBeatData;
  logic           memCredit;

  // three fields per request in the data file
  logic [63:0]    stim [3*maxReq];
  cachePkg::addrT testAddr [maxReq];
  cachePkg::wordT testWord [maxReq];
  logic           testMiss [maxReq];
  bit             testBad [maxReq];

  int             nReq;
  int             reqSent;
  int             respCount;
  int             passCount;
  int             errCount;
  int             reqCredits;
  int             memCredits;
  int             reqGap;
  int             memGap;
  int             beatsLeft;
  int             missCount;
  int             reqCreditTotal;
  int             memCreditTotal;
  int             cycles;
  int             cycleLimit;
  bit             sawMiss;
  bit             timedOut;
  cachePkg::addrT beatAddr;
  logic [31:0]    lcgState;

  `include "cacheTbChecks.svh"

  cacheTop uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .reqValid_i     (reqValid),
    .reqAddr_i      (reqAddr),
    .reqCredit_o    (reqCredit),
    .rdValid_o      (rdValid),
    .rdData_o       (rdData),
    .memReqValid_o  (memReqValid),
    .memReqAddr_o   (memReqAddr),
    .memBeatValid_i (memBeatValid),
    .memBeatData_i  (memBeatData),
    .memCredit_o    (memCredit)
  );

  initial begin
    clk = 1'b0;
    forever #halfCycle clk = ~clk;
  end

  function automatic int nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return {17'd0, lcgState[30:16]};
  endfunction

  task automatic loadTests();
    // all ones marks the end since no 32-bit address reaches it
    for (int i = 0; i < 3*maxReq; i++) begin
      stim[i] = '1;
    end
    $readmemh("tests/cacheTests.mem", stim);
    nReq = 0;
    while (nReq < maxReq && stim[3*nReq] != '1) begin
      testAddr[nReq] = stim[3*nReq][31:0];
      testWord[nReq] = stim[3*nReq+1];
      testMiss[nReq] = stim[3*nReq+2][0];
      testBad[nReq]  = 1'b0;
      nReq++;
    end
  endtask

  task automatic watchOutputs(output bit gotReqCredit, output bit gotMemCredit);
    bit ok;
    if (rdValid) begin
      if (respCount >= reqSent) begin
        errCount++;
        $display("response at %0t ns with no request outstanding", $time);
      end else begin
        checkWord($sformatf("test %0d", respCount), rdData, testWord[respCount], ok);
        testBad[respCount] |= !ok;
        checkHit($sformatf("test %0d", respCount), sawMiss, testMiss[respCount], ok);
        testBad[respCount] |= !ok;
        $display("test %0d addr %h %s %s", respCount, testAddr[respCount],
                 sawMiss ? "miss" : "hit", testBad[respCount] ? "FAILED" : "ok");
        if (!testBad[respCount]) begin
          passCount++;
        end
        sawMiss = 1'b0;
        respCount++;
      end
    end
    if (memReqValid) begin
      if (sawMiss || beatsLeft != 0 || memCredits != cachePkg::fifoDepth) begin
        errCount++;
        $display("memory request at %0t ns before the previous refill completed", $time);
      end
      if (respCount < reqSent) begin
        // expected line is the request address with the offset bits cleared
        checkAddr($sformatf("test %0d", respCount), memReqAddr,
                  testAddr[respCount] & 32'hFFFF_FFE0, ok);
        testBad[respCount] |= !ok;
      end else begin
        errCount++;
        $display("memory request at %0t ns with no request outstanding", $time);
      end
      sawMiss   = 1'b1;
      missCount++;
      beatsLeft = cachePkg::beatsPerLine;
      beatAddr  = memReqAddr;
    end
    gotReqCredit = reqCredit;
    gotMemCredit = memCredit;
    reqCreditTotal += int'(reqCredit);
    memCreditTotal += int'(memCredit);
  endtask

  // line words carry the address in the upper half and its inverse below
  task automatic driveMemory();
    memBeatValid = 1'b0;
    if (beatsLeft > 0) begin
      if (memGap > 0) begin
        memGap--;
      end else if (memCredits > 0) begin
        memBeatValid = 1'b1;
        memBeatData  = {beatAddr, ~beatAddr};
        beatAddr     = beatAddr + 32'd8;
        beatsLeft--;
        memCredits--;
        memGap = nextRand() % 3;
      end
    end
  endtask

  task automatic driveRequests();
    reqValid = 1'b0;
    if (reqSent < nReq) begin
      if (reqGap > 0) begin
        reqGap--;
      end else if (reqCredits > 0) begin
        reqValid = 1'b1;
        reqAddr  = testAddr[reqSent];
        reqSent++;
        reqCredits--;
        reqGap = nextRand() % 3;
      end
    end
  endtask

  // credits seen this cycle are spent from the next one on
  task automatic stepCycle();
    bit rc;
    bit mc;
    @(negedge clk);
    watchOutputs(rc, mc);
    driveMemory();
    driveRequests();
    reqCredits += int'(rc);
    memCredits += int'(mc);
    if (reqCredits > cachePkg::fifoDepth || memCredits > cachePkg::fifoDepth) begin
      errCount++;
      $display("more credits returned than entries were sent at %0t ns", $time);
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    reqValid     = 1'b0;
    reqAddr      = '0;
    memBeatValid = 1'b0;
    memBeatData  = '0;
    lcgState     = 32'd22547;
    reqSent      = 0;
    respCount    = 0;
    passCount    = 0;
    errCount     = 0;
    reqCredits   = cachePkg::fifoDepth;
    memCredits   = cachePkg::fifoDepth;
    reqGap       = 0;
    memGap       = 0;
    beatsLeft    = 0;
    missCount    = 0;
    reqCreditTotal = 0;
    memCreditTotal = 0;
    cycles       = 0;
    sawMiss      = 1'b0;
    timedOut     = 1'b0;
    loadTests();
    if (nReq == 0) begin
      errCount++;
      $display("no requests were read from the test file");
    end
    cycleLimit = 40 * nReq;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    while (respCount < nReq && !timedOut) begin
      stepCycle();
      cycles++;
      if (cycles >= cycleLimit) begin
        timedOut = 1'b1;
        errCount++;
        $display("timeout after %0d cycles with %0d of %0d responses received",
                 cycles, respCount, nReq);
      end
    end
    // a few idle cycles catch stray responses and memory requests
    repeat (8) stepCycle();
    if (reqCreditTotal != nReq) begin
      errCount++;
      $display("request credits returned %0d times for %0d requests", reqCreditTotal, nReq);
    end
    if (memCreditTotal != cachePkg::beatsPerLine * missCount) begin
      errCount++;
      $display("memory credits returned %0d times for %0d refills", memCreditTotal, missCount);
    end
    $display("tests %0d passed %0d failed %0d errors %0d",
             nReq, passCount, nReq - passCount, errCount);
    if (errCount == 0 && passCount == nReq && !timedOut) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/cacheTests.mem */
// columns: request address, expected word, 1 for miss or 0 for hit
// sets 0, 1, 2, 31 and 51; lines 0x1000, 0x1800 and 0x2000 share set 0
00001008 00001008FFFFEFF7 1
00001000 00001000FFFFEFFF 0
00001018 00001018FFFFEFE7 0
00001010 00001010FFFFEFEF 0
00001800 00001800FFFFE7FF 1
00001008 00001008FFFFEFF7 0
00001818 00001818FFFFE7E7 0
// third line in set 0 evicts the older way
00002010 00002010FFFFDFEF 1
00001808 00001808FFFFE7F7 0
00001000 00001000FFFFEFFF 1
00002000 00002000FFFFDFFF 1
00001018 00001018FFFFEFE7 0
00000040 00000040FFFFFFBF 1
00000048 00000048FFFFFFB7 0
00000050 00000050FFFFFFAF 0
00000058 00000058FFFFFFA7 0
00002018 00002018FFFFDFE7 0
00001008 00001008FFFFEFF7 0
// five requests queue behind this refill
000003E0 000003E0FFFFFC1F 1
00000040 00000040FFFFFFBF 0
00000058 00000058FFFFFFA7 0
000003F8 000003F8FFFFFC07 0
00001010 00001010FFFFEFEF 0
00002008 00002008FFFFDFF7 0
80000020 800000207FFFFFDF 1
80000038 800000387FFFFFC7 0
12345678 12345678EDCBA987 1
12345660 12345660EDCBA99F 0
